// File: src/frontend_consts.svh
/* fetch-side constants; FETCH_FIFO_DEPTH must be a power of two and
   also sets the number of fetch credits out of reset */
`ifndef FRONTEND_CONSTS_SVH
`define FRONTEND_CONSTS_SVH

// ------------------------------------------------------------
// fetch flow control
// ------------------------------------------------------------
// entries in the fetch FIFO, same as the credit count at reset
`define FETCH_FIFO_DEPTH 4

// ------------------------------------------------------------
// addresses
// ------------------------------------------------------------
// one uncompressed instruction per fetch
`define INSTR_BYTES 4
// first fetch after reset
`define BOOT_ADDR 64'h8000_0000
// debug entry, hard-wired
`define DEBUG_HALT_ADDR 64'h800

// vaddr + instr + pred taken + pred addr + exception
`define FETCH_ENTRY_W 162

`endif

// File: src/addr_pkg.sv
/* address and instruction word types; Sv64-style virtual addresses,
   no compressed instructions */
package addr_pkg;

    // ------------------------------------------------------------
    // address and instruction words
    // ------------------------------------------------------------
    // virtual address, full 64 bits
    typedef logic [63:0] addr_t;

    // one uncompressed RISC-V instruction
    typedef logic [31:0] instr_t;

endpackage

// File: src/fetch_pkg.sv
/* fetch flow types; entry layout is fixed by FETCH_ENTRY_W */
`include "frontend_consts.svh"

package fetch_pkg;

    // credit count, one extra bit so a full count of DEPTH fits
    typedef logic [$clog2(`FETCH_FIFO_DEPTH):0] credit_t;

    // packed fetch entry, top down:
    // vaddr[63:0], instr[31:0], pred taken, pred addr[63:0], exception
    typedef logic [`FETCH_ENTRY_W-1:0] fetch_entry_t;

endpackage

// File: src/instr_scan.sv
/* RVI only: compressed words are not recognized, jalr is not flagged */
`timescale 1ns/1ps

module instr_scan (
    input  addr_pkg::instr_t instr_i,
    output logic             is_branch_o,
    output logic             is_jump_o,
    output addr_pkg::addr_t  imm_o
);

    // major opcodes of interest
    localparam logic [6:0] OPCODE_BRANCH = 7'b110_0011;
    localparam logic [6:0] OPCODE_JAL    = 7'b110_1111;

    logic [6:0]      opcode;
    addr_pkg::addr_t imm_b;
    addr_pkg::addr_t imm_j;

    assign opcode = instr_i[6:0];

    // ------------------------------------------------------------
    // immediates
    // ------------------------------------------------------------
    // B-format: imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
    assign imm_b = {
        {51{instr_i[31]}},
        instr_i[31],
        instr_i[7],
        instr_i[30:25],
        instr_i[11:8],
        1'b0
    };

    // J-format: imm[20|10:1|11|19:12] in 31:12
    assign imm_j = {
        {43{instr_i[31]}},
        instr_i[31],
        instr_i[19:12],
        instr_i[20],
        instr_i[30:21],
        1'b0
    };

    // ------------------------------------------------------------
    // classification
    // ------------------------------------------------------------
    // all conditional branches share one opcode, funct3 is irrelevant here
    assign is_branch_o = (opcode == OPCODE_BRANCH);
    assign is_jump_o   = (opcode == OPCODE_JAL);

    // sign bit of imm_o drives the backward-taken rule
    assign imm_o = is_jump_o ? imm_j : imm_b;

endmodule

// File: src/pc_gen.sv
/* redirect strobes are single-cycle; a later strobe wins over an
   earlier one, debug entry is highest */
`timescale 1ns/1ps
`include "frontend_consts.svh"

module pc_gen (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            issue_i,
    input  logic            bp_valid_i,
    input  addr_pkg::addr_t bp_addr_i,
    input  logic            mispredict_i,
    input  addr_pkg::addr_t mispredict_addr_i,
    input  logic            eret_i,
    input  addr_pkg::addr_t epc_i,
    input  logic            ex_valid_i,
    input  addr_pkg::addr_t trap_vector_base_i,
    input  logic            set_pc_commit_i,
    input  addr_pkg::addr_t pc_commit_i,
    input  logic            set_debug_pc_i,
    output addr_pkg::addr_t fetch_addr_o
);

    addr_pkg::addr_t npc_d, npc_q;
    addr_pkg::addr_t fetch_addr;
    // high for the first cycle out of reset
    logic            rst_load_q;

    always_comb begin : npc_select
        // out of reset the boot address stands in for npc_q
        if (rst_load_q) begin
            fetch_addr = `BOOT_ADDR;
            npc_d      = `BOOT_ADDR;
        end else begin
            fetch_addr = npc_q;
            npc_d      = npc_q;
        end

        // ------------------------------------------------------------
        // static prediction, overrides the address this cycle
        // ------------------------------------------------------------
        if (bp_valid_i) begin
            fetch_addr = bp_addr_i;
            npc_d      = bp_addr_i;
        end

        // sequential step from the word-aligned request address
        if (issue_i) begin
            npc_d = {fetch_addr[63:2], 2'b00} + addr_pkg::addr_t'(`INSTR_BYTES);
        end

        // ------------------------------------------------------------
        // redirects, lowest priority first
        // ------------------------------------------------------------
        if (mispredict_i) begin
            npc_d = mispredict_addr_i;
        end
        if (eret_i) begin
            npc_d = epc_i;
        end
        if (ex_valid_i) begin
            npc_d = trap_vector_base_i;
        end
        // commit-stage flush resumes after the flushing instruction
        if (set_pc_commit_i) begin
            npc_d = pc_commit_i + addr_pkg::addr_t'(`INSTR_BYTES);
        end
        if (set_debug_pc_i) begin
            npc_d = `DEBUG_HALT_ADDR;
        end
    end

    assign fetch_addr_o = fetch_addr;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            npc_q      <= '0;
            rst_load_q <= 1'b1;
        end else begin
            npc_q      <= npc_d;
            rst_load_q <= 1'b0;
        end
    end

endmodule

// File: src/fetch_credit.sv
/* one credit per FIFO slot; tracks one in-flight request only, so a
   kill returns at most one credit per cycle */
`timescale 1ns/1ps
`include "frontend_consts.svh"

module fetch_credit (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    input  logic ready_i,
    input  logic kill_s1_i,
    input  logic kill_s2_i,
    input  logic rsp_valid_i,
    input  logic pop_i,
    output logic credit_avail_o,
    output logic issue_o
);

    fetch_pkg::credit_t credits_d, credits_q;
    logic               in_flight_d, in_flight_q;
    // request in flight that gets cancelled this cycle
    logic               eff_kill;

    assign credit_avail_o = |credits_q;

    // a killed request never counts as issued
    assign issue_o  = credit_avail_o & ready_i & ~kill_s1_i;
    assign eff_kill = in_flight_q & kill_s2_i;

    // ------------------------------------------------------------
    // credit count and in-flight flag
    // ------------------------------------------------------------
    assign credits_d = flush_i ? fetch_pkg::credit_t'(`FETCH_FIFO_DEPTH) :
                       fetch_pkg::credit_t'(credits_q
                                            + fetch_pkg::credit_t'(pop_i)
                                            + fetch_pkg::credit_t'(eff_kill)
                                            - fetch_pkg::credit_t'(issue_o));

    // a new issue keeps the flag up even if a response lands this cycle
    assign in_flight_d = flush_i     ? 1'b0 :
                         issue_o     ? 1'b1 :
                         rsp_valid_i ? 1'b0 :
                                       in_flight_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            credits_q   <= fetch_pkg::credit_t'(`FETCH_FIFO_DEPTH);
            in_flight_q <= 1'b0;
        end else begin
            credits_q   <= credits_d;
            in_flight_q <= in_flight_d;
        end
    end

endmodule

// File: src/fetch_fifo.sv
/* depth must be a power of two; a push while full is dropped, the
   credit scheme keeps that from happening */
`timescale 1ns/1ps
`include "frontend_consts.svh"

module fetch_fifo (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  logic                    push_i,
    input  fetch_pkg::fetch_entry_t data_i,
    input  logic                    pop_i,
    output fetch_pkg::fetch_entry_t data_o,
    output logic                    empty_o
);

    localparam int unsigned PTR_W = $clog2(`FETCH_FIFO_DEPTH);

    // storage, no reset needed
    fetch_pkg::fetch_entry_t mem_q [`FETCH_FIFO_DEPTH];

    logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             full;
    logic             do_push, do_pop;

    assign empty_o = (count_q == '0);
    assign full    = (count_q == (PTR_W+1)'(`FETCH_FIFO_DEPTH));

    assign do_push = push_i & ~full;
    assign do_pop  = pop_i & ~empty_o;

    // head of queue, visible the cycle after its push
    assign data_o = mem_q[rd_ptr_q];

    // ------------------------------------------------------------
    // pointers and fill count
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // flush wins over push and pop in the same cycle
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // pointers wrap naturally, depth is a power of two
            if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_q + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
        end
    end

    // ------------------------------------------------------------
    // storage write
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (do_push && !flush_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

// File: src/frontend.sv
/* 32-bit fetch of aligned RVI words only; the cache must drop any
   response whose kill_s2 was raised for it */
`timescale 1ns/1ps

module frontend (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             flush_i,
    input  logic             mispredict_i,
    input  addr_pkg::addr_t  mispredict_addr_i,
    input  logic             eret_i,
    input  addr_pkg::addr_t  epc_i,
    input  logic             ex_valid_i,
    input  addr_pkg::addr_t  trap_vector_base_i,
    input  logic             set_pc_commit_i,
    input  addr_pkg::addr_t  pc_commit_i,
    input  logic             set_debug_pc_i,
    // instruction cache
    output logic             icache_req_o,
    output addr_pkg::addr_t  icache_vaddr_o,
    input  logic             icache_ready_i,
    output logic             icache_kill_s1_o,
    output logic             icache_kill_s2_o,
    input  logic             icache_valid_i,
    input  addr_pkg::instr_t icache_data_i,
    input  addr_pkg::addr_t  icache_rsp_vaddr_i,
    input  logic             icache_ex_i,
    // toward decode
    output logic             fetch_valid_o,
    output addr_pkg::addr_t  fetch_vaddr_o,
    output addr_pkg::instr_t fetch_instr_o,
    output logic             fetch_pred_taken_o,
    output addr_pkg::addr_t  fetch_pred_addr_o,
    output logic             fetch_ex_o,
    input  logic             fetch_ack_i
);

    // registered cache response, payload has no reset
    logic             rsp_valid_q;
    addr_pkg::instr_t rsp_data_q;
    addr_pkg::addr_t  rsp_vaddr_q;
    logic             rsp_ex_q;

    logic                    is_branch, is_jump;
    addr_pkg::addr_t         imm, bp_addr;
    logic                    bp_valid, issue, fifo_pop, fifo_empty;
    fetch_pkg::fetch_entry_t entry_in, entry_out;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= icache_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (icache_valid_i) begin
            rsp_data_q  <= icache_data_i;
            rsp_vaddr_q <= icache_rsp_vaddr_i;
            rsp_ex_q    <= icache_ex_i;
        end
    end

    instr_scan i_instr_scan (
        .instr_i     ( rsp_data_q ),
        .is_branch_o ( is_branch  ),
        .is_jump_o   ( is_jump    ),
        .imm_o       ( imm        )
    );

    // ------------------------------------------------------------
    // static prediction and kills
    // ------------------------------------------------------------
    // backward branch taken, forward not taken, jal always taken
    assign bp_valid = rsp_valid_q & (is_jump | (is_branch & imm[63]));
    assign bp_addr  = rsp_vaddr_q + imm;

    assign icache_kill_s1_o = flush_i | mispredict_i;
    // a taken prediction makes the request behind it stale
    assign icache_kill_s2_o = icache_kill_s1_o | bp_valid;

    pc_gen i_pc_gen (
        .clk_i, .rst_ni,
        .issue_i            ( issue              ),
        .bp_valid_i         ( bp_valid           ),
        .bp_addr_i          ( bp_addr            ),
        .mispredict_i, .mispredict_addr_i, .eret_i, .epc_i,
        .ex_valid_i, .trap_vector_base_i, .set_pc_commit_i, .pc_commit_i,
        .set_debug_pc_i,
        .fetch_addr_o       ( icache_vaddr_o     )
    );

    fetch_credit i_fetch_credit (
        .clk_i, .rst_ni, .flush_i,
        .ready_i        ( icache_ready_i   ),
        .kill_s1_i      ( icache_kill_s1_o ),
        .kill_s2_i      ( icache_kill_s2_o ),
        .rsp_valid_i    ( icache_valid_i   ),
        .pop_i          ( fifo_pop         ),
        .credit_avail_o ( icache_req_o     ),
        .issue_o        ( issue            )
    );

    // ------------------------------------------------------------
    // fetch FIFO toward decode
    // ------------------------------------------------------------
    // pred addr is zero when not taken
    assign entry_in = {rsp_vaddr_q, rsp_data_q, bp_valid,
                       (bp_valid ? bp_addr : '0), rsp_ex_q};
    assign fifo_pop = fetch_valid_o & fetch_ack_i;

    fetch_fifo i_fetch_fifo (
        .clk_i, .rst_ni, .flush_i,
        .push_i  ( rsp_valid_q ),
        .data_i  ( entry_in    ),
        .pop_i   ( fifo_pop    ),
        .data_o  ( entry_out   ),
        .empty_o ( fifo_empty  )
    );

    assign fetch_valid_o      = ~fifo_empty;
    assign fetch_vaddr_o      = entry_out[161:98];
    assign fetch_instr_o      = entry_out[97:66];
    assign fetch_pred_taken_o = entry_out[65];
    assign fetch_pred_addr_o  = entry_out[64:1];
    assign fetch_ex_o         = entry_out[0];

endmodule

// File: tests/tb_frontend.sv
/* cache model answers one cycle after issue and drops killed responses;
   only the control-flow words placed in mem_word are branches or jumps */
`timescale 1ns/1ps
`include "frontend_consts.svh"

module tb_frontend;

    // the longest run is well under 2000 cycles, the limit is twice that
    localparam int          MAX_CYCLES  = 4000;
    localparam logic [63:0] CTRL_BASE   = `BOOT_ADDR + 64'h1000;
    localparam logic [63:0] EPC_ADDR    = `BOOT_ADDR + 64'h3000;
    localparam logic [63:0] TRAP_ADDR   = `BOOT_ADDR + 64'h4000;
    localparam logic [63:0] COMMIT_ADDR = `BOOT_ADDR + 64'h5000;

    logic clk_i, rst_ni, flush_i, mispredict_i, eret_i, ex_valid_i;
    logic set_pc_commit_i, set_debug_pc_i;
    logic [63:0] mispredict_addr_i, epc_i, trap_vector_base_i, pc_commit_i;
    logic icache_req_o, icache_kill_s1_o, icache_kill_s2_o, icache_valid_i;
    logic [63:0] icache_vaddr_o;
    logic icache_ready_i = 1'b0;
    logic icache_ex_i = 1'b0;
    logic fetch_ack_i = 1'b0;
    logic [31:0] icache_data_i = '0;
    logic [63:0] icache_rsp_vaddr_i = '0;
    logic fetch_valid_o, fetch_pred_taken_o, fetch_ex_o;
    logic [63:0] fetch_vaddr_o, fetch_pred_addr_o;
    logic [31:0] fetch_instr_o;

    // cache model state
    logic        issued_q = 1'b0;
    logic [63:0] issued_addr_q = '0;
    logic        rsp_pending = 1'b0;
    // test control and bookkeeping
    integer      seed = 32'hee9f_c003;
    logic [63:0] exp_addr = `BOOT_ADDR;
    logic [63:0] ex_addr = '1;
    logic        bp_mode = 1'b0;
    int          stall_left = 0;
    int          pop_count = 0, pops_target = 0, cycle_count = 0;
    int          check_count = 0, error_count = 0, first_pop, first_err;
    string       test_name = "reset";

    frontend UUT (.*);

    // a response is dropped while kill_s2 is up
    assign icache_valid_i = rsp_pending & ~icache_kill_s2_o;

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    // bne x1, x2 with a 13-bit byte offset
    function automatic logic [31:0] branch_word(input logic [12:0] off);
        branch_word = {off[12], off[10:5], 5'd2, 5'd1, 3'b001, off[4:1], off[11],
                       7'b110_0011};
    endfunction

    // jal x0 with a 21-bit byte offset
    function automatic logic [31:0] jal_word(input logic [20:0] off);
        jal_word = {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b110_1111};
    endfunction

    // addi-type fill from all address bits, except a small control-flow region
    function automatic logic [31:0] mem_word(input logic [63:0] addr);
        logic [31:0] h;
        h = addr[31:0] ^ addr[63:32];
        mem_word = {h[31:7] ^ {20'b0, h[6:2]}, 7'b001_0011};
        if (addr == CTRL_BASE + 64'h08) begin
            mem_word = branch_word(13'd16);
        end else if (addr == CTRL_BASE + 64'h10) begin
            mem_word = jal_word(21'h30);
        end else if (addr == CTRL_BASE + 64'h48) begin
            mem_word = branch_word(-13'sd16);
        end
    endfunction

    // backward branch taken, forward not taken, jal always taken
    function automatic logic [63:0] next_expected(input logic [63:0] addr,
                                                  input logic [31:0] instr);
        logic [63:0] imm;
        next_expected = addr + `INSTR_BYTES;
        if (instr[6:0] == 7'b110_1111) begin
            imm = $signed({instr[31], instr[19:12], instr[20], instr[30:21], 1'b0});
            next_expected = addr + imm;
        end else if (instr[6:0] == 7'b110_0011 && instr[31]) begin
            imm = $signed({instr[31], instr[7], instr[30:25], instr[11:8], 1'b0});
            next_expected = addr + imm;
        end
    endfunction

    // mask bits: 0 mispredict, 1 eret, 2 exception, 3 commit, 4 debug
    function automatic logic [63:0] redirect_target(input logic [4:0] mask);
        if (mask[4]) redirect_target = `DEBUG_HALT_ADDR;
        else if (mask[3]) redirect_target = COMMIT_ADDR + `INSTR_BYTES;
        else if (mask[2]) redirect_target = TRAP_ADDR;
        else if (mask[1]) redirect_target = EPC_ADDR;
        else redirect_target = CTRL_BASE;
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: expected %h, actual %h", what, expected, actual);
        end
    endtask

    // ------------------------------------------------------------
    // cache model and decode-side acknowledge
    // ------------------------------------------------------------
    // pre-edge outputs, so what the DUT saw at this edge
    always @(posedge clk_i) begin : sample_issue
        issued_q      <= rst_ni & icache_req_o & icache_ready_i & ~icache_kill_s1_o;
        issued_addr_q <= icache_vaddr_o;
    end

    always @(negedge clk_i) begin : drive_cache_and_ack
        logic want;
        rsp_pending        = issued_q;
        icache_rsp_vaddr_i = issued_addr_q;
        icache_data_i      = mem_word(issued_addr_q);
        icache_ex_i        = (issued_addr_q == ex_addr);
        icache_ready_i     = ({$random(seed)} % 4) != 0;
        want = (pop_count < pops_target);
        if (bp_mode && stall_left > 0) begin
            stall_left  = stall_left - 1;
            fetch_ack_i = 1'b0;
        end else begin
            fetch_ack_i = want;
            // one accepted cycle, then a random stall
            if (bp_mode && want) stall_left = {$random(seed)} % 16;
        end
    end

    // every popped entry against the expected stream
    always @(posedge clk_i) begin : compare_entries
        logic [63:0] next_addr;
        logic        taken;
        if (rst_ni && fetch_valid_o && fetch_ack_i) begin
            next_addr = next_expected(exp_addr, mem_word(exp_addr));
            taken     = (next_addr != exp_addr + `INSTR_BYTES);
            check_value({test_name, " vaddr"}, exp_addr, fetch_vaddr_o);
            check_value({test_name, " instr"}, mem_word(exp_addr), fetch_instr_o);
            check_value({test_name, " pred_taken"}, taken, fetch_pred_taken_o);
            if (taken) check_value({test_name, " pred_addr"}, next_addr, fetch_pred_addr_o);
            check_value({test_name, " ex"}, exp_addr == ex_addr, fetch_ex_o);
            exp_addr  = next_addr;
            pop_count = pop_count + 1;
        end
    end

    always @(posedge clk_i) begin : watchdog
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // test sequencing
    // ------------------------------------------------------------
    task automatic start_test(input string name);
        test_name = name;
        first_pop = pop_count;
        first_err = error_count;
    endtask

    task automatic end_test();
        $display("%s: %0d entries popped, %0d errors", test_name,
                 pop_count - first_pop, error_count - first_err);
    endtask

    // lets n more entries pop and waits for them
    task automatic wait_pops(input int n);
        @(posedge clk_i);
        pops_target <= pops_target + n;
        @(negedge clk_i);
        while (pop_count < pops_target) @(negedge clk_i);
    endtask

    // flush plus a set of redirect strobes for one cycle
    task automatic redirect(input logic [4:0] mask);
        @(negedge clk_i);
        flush_i         = 1'b1;
        mispredict_i    = mask[0];
        eret_i          = mask[1];
        ex_valid_i      = mask[2];
        set_pc_commit_i = mask[3];
        set_debug_pc_i  = mask[4];
        exp_addr        = redirect_target(mask);
        // a flush cancels both the new request and the one in flight
        @(posedge clk_i);
        check_value({test_name, " kill_s1"}, 1, icache_kill_s1_o);
        check_value({test_name, " kill_s2"}, 1, icache_kill_s2_o);
        @(negedge clk_i);
        flush_i         = 1'b0;
        mispredict_i    = 1'b0;
        eret_i          = 1'b0;
        ex_valid_i      = 1'b0;
        set_pc_commit_i = 1'b0;
        set_debug_pc_i  = 1'b0;
    endtask

    initial begin : run_tests
        rst_ni             = 1'b0;
        flush_i            = 1'b0;
        mispredict_i       = 1'b0;
        eret_i             = 1'b0;
        ex_valid_i         = 1'b0;
        set_pc_commit_i    = 1'b0;
        set_debug_pc_i     = 1'b0;
        mispredict_addr_i  = CTRL_BASE;
        epc_i              = EPC_ADDR;
        trap_vector_base_i = TRAP_ADDR;
        pc_commit_i        = COMMIT_ADDR;
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        start_test("boot");
        // out of reset: full credits, nothing to cancel, boot address up
        @(posedge clk_i);
        check_value({test_name, " icache_req"}, 1, icache_req_o);
        check_value({test_name, " kill_s1"}, 0, icache_kill_s1_o);
        check_value({test_name, " kill_s2"}, 0, icache_kill_s2_o);
        check_value({test_name, " icache_vaddr"}, `BOOT_ADDR, icache_vaddr_o);
        check_value({test_name, " fetch_valid"}, 0, fetch_valid_o);
        wait_pops(1);
        end_test();

        start_test("sequential");
        wait_pops(32);
        end_test();

        // forward branch, jal, then a backward branch loop
        start_test("prediction");
        redirect(5'b00001);
        wait_pops(16);
        end_test();

        start_test("priority");
        for (int m = 1; m < 32; m++) begin
            redirect(5'(m));
            wait_pops(3);
        end
        end_test();

        start_test("backpressure");
        redirect(5'b00010);
        @(posedge clk_i);
        bp_mode <= 1'b1;
        wait_pops(48);
        @(posedge clk_i);
        bp_mode <= 1'b0;
        end_test();

        start_test("exception");
        @(posedge clk_i);
        ex_addr <= TRAP_ADDR + 64'h8;
        redirect(5'b00100);
        wait_pops(4);
        end_test();

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: frontend.f
+incdir+src
src/addr_pkg.sv
src/fetch_pkg.sv
src/instr_scan.sv
src/pc_gen.sv
src/fetch_credit.sv
src/fetch_fifo.sv
src/frontend.sv
tests/tb_frontend.sv

// File: Bender.yml
package:
  name: frontend

sources:
  - include_dirs:
      - src
    files:
      - src/addr_pkg.sv
      - src/fetch_pkg.sv
      - src/instr_scan.sv
      - src/pc_gen.sv
      - src/fetch_credit.sv
      - src/fetch_fifo.sv
      - src/frontend.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/tb_frontend.sv
